// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int WORD_W = 32;                // Register and address width
    localparam int BYTE_W = 8;                 // Width of one memory lane
    localparam logic [3:0] R0_IDX = 4'd0;      // Fixed target of disp loads

    typedef logic [WORD_W-1:0] word_t;         // Register value or address
    typedef logic [15:0]       raw_t;          // Raw 16-bit instruction
    typedef logic [3:0]        reg_idx_t;      // GPR number
    typedef logic [1:0]        byte_ofs_t;     // Byte offset in bus word
    typedef logic [3:0]        wmask_t;        // Byte write enables

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,                        // 8 bit
        SZ_WORD = 2'd1,                        // 16 bit
        SZ_LONG = 2'd2                         // 32 bit
    } acc_size_t;

    typedef enum logic [2:0] {
        AM_RN,                                 // @Rn or @Rm
        AM_PREDEC,                             // @-Rn
        AM_POSTINC,                            // @Rm+
        AM_DISP_RN,                            // @(disp,Rn)
        AM_R0_RN,                              // @(R0,Rn)
        AM_DISP_GBR,                           // @(disp,GBR)
        AM_R0_GBR                              // @(R0,GBR), byte RMW only
    } addr_mode_t;

    typedef enum logic [1:0] {
        RMW_NONE,
        RMW_AND,
        RMW_OR,
        RMW_XOR
    } rmw_op_t;

    typedef enum logic {
        RMW_READ  = 1'b0,                      // First pass fetches old byte
        RMW_WRITE = 1'b1                       // Second pass stores result
    } rmw_state_t;

    // Access size in bytes, also the pre/post step
    function automatic word_t size_bytes(acc_size_t sz);
        return word_t'(1) << sz;
    endfunction

endpackage

`default_nettype wire

// File: design/lsu_e2_if.sv
`timescale 1ns/100ps
`default_nettype none

// Access record held between E1 and E2
interface lsu_e2_if
    import lsu_pkg::*;
();

    logic      valid;                          // Request went out last cycle
    logic      is_store;                       // No load data expected
    logic      is_rmw;                         // Byte read-modify-write pass
    acc_size_t size;                           // Extraction width
    byte_ofs_t byte_ofs;                       // Lane offset of the access
    reg_idx_t  wdst;                           // Load destination register

    // Register side
    modport e1 (
        output valid, is_store, is_rmw, size, byte_ofs, wdst
    );

    // Consumer side
    modport e2 (
        input valid, is_store, is_rmw, size, byte_ofs, wdst
    );

endinterface

`default_nettype wire

// File: design/lsu_decode.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_decode
    import lsu_pkg::*;
(
    input  raw_t       raw,
    input  rmw_state_t rmw_state,
    output logic       is_load,
    output logic       is_store,
    output logic       is_rmw,
    output acc_size_t  size,
    output addr_mode_t mode,
    output reg_idx_t   wdst,
    output rmw_op_t    rmw_op
);

    always_comb
    begin
        is_load  = 1'b0;                       // Not a memory op by default
        is_store = 1'b0;
        is_rmw   = 1'b0;
        size     = SZ_LONG;
        mode     = AM_RN;
        wdst     = raw[11:8];                  // Rn field
        rmw_op   = RMW_NONE;

        casez (raw)
            16'b0010????????0000,              // MOV.x Rm,@Rn
            16'b0010????????0001,
            16'b0010????????0010:
            begin
                is_store = 1'b1;
                size     = acc_size_t'(raw[1:0]);
            end
            16'b0010????????0100,              // MOV.x Rm,@-Rn
            16'b0010????????0101,
            16'b0010????????0110:
            begin
                is_store = 1'b1;
                mode     = AM_PREDEC;
                size     = acc_size_t'(raw[1:0]);
            end
            16'b10000000????????,              // MOV.B R0,@(disp,Rn)
            16'b10000001????????:              // MOV.W R0,@(disp,Rn)
            begin
                is_store = 1'b1;
                mode     = AM_DISP_RN;
                size     = raw[8] ? SZ_WORD : SZ_BYTE;
            end
            16'b0001????????????:              // MOV.L Rm,@(disp,Rn)
            begin
                is_store = 1'b1;
                mode     = AM_DISP_RN;
            end
            16'b0000????????0100,              // MOV.x Rm,@(R0,Rn)
            16'b0000????????0101,
            16'b0000????????0110:
            begin
                is_store = 1'b1;
                mode     = AM_R0_RN;
                size     = acc_size_t'(raw[1:0]);
            end
            16'b11000000????????,              // MOV.x R0,@(disp,GBR)
            16'b11000001????????,
            16'b11000010????????:
            begin
                is_store = 1'b1;
                mode     = AM_DISP_GBR;
                size     = acc_size_t'(raw[9:8]);
            end
            16'b0110????????0000,              // MOV.x @Rm,Rn
            16'b0110????????0001,
            16'b0110????????0010:
            begin
                is_load = 1'b1;
                size    = acc_size_t'(raw[1:0]);
            end
            16'b0110????????0100,              // MOV.x @Rm+,Rn
            16'b0110????????0101,
            16'b0110????????0110:
            begin
                is_load = 1'b1;
                mode    = AM_POSTINC;
                size    = acc_size_t'(raw[1:0]);
            end
            16'b10000100????????,              // MOV.B @(disp,Rm),R0
            16'b10000101????????:              // MOV.W @(disp,Rm),R0
            begin
                is_load = 1'b1;
                mode    = AM_DISP_RN;
                size    = raw[8] ? SZ_WORD : SZ_BYTE;
                wdst    = R0_IDX;
            end
            16'b0101????????????:              // MOV.L @(disp,Rm),Rn
            begin
                is_load = 1'b1;
                mode    = AM_DISP_RN;
            end
            16'b0000????????1100,              // MOV.x @(R0,Rm),Rn
            16'b0000????????1101,
            16'b0000????????1110:
            begin
                is_load = 1'b1;
                mode    = AM_R0_RN;
                size    = acc_size_t'(raw[1:0]);
            end
            16'b11000100????????,              // MOV.x @(disp,GBR),R0
            16'b11000101????????,
            16'b11000110????????:
            begin
                is_load = 1'b1;
                mode    = AM_DISP_GBR;
                size    = acc_size_t'(raw[9:8]);
                wdst    = R0_IDX;
            end
            16'b110011??????????:              // AND/OR/XOR.B #imm,@(R0,GBR)
            begin
                if (raw[9:8] != 2'b00)         // 0xCC is TST.B, not kept
                begin
                    is_rmw   = 1'b1;
                    is_load  = (rmw_state == RMW_READ);   // Read pass
                    is_store = (rmw_state == RMW_WRITE);  // Write pass
                    mode     = AM_R0_GBR;
                    size     = SZ_BYTE;
                    rmw_op   = (raw[9:8] == 2'b01) ? RMW_AND :
                               (raw[9:8] == 2'b11) ? RMW_OR : RMW_XOR;
                end
            end
            default:
            begin
                // Not a load/store of this unit
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/lsu_agen.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_agen
    import lsu_pkg::*;
(
    input  word_t      opl,                    // R[raw[7:4]]
    input  word_t      oph,                    // R[raw[11:8]]
    input  word_t      r0,
    input  word_t      gbr,
    input  logic [7:0] imm,
    input  addr_mode_t mode,
    input  acc_size_t  size,
    input  logic       is_load,
    input  logic       is_rmw,
    input  reg_idx_t   rl,
    input  reg_idx_t   rh,
    output word_t      addr,
    output logic       e1_wen,
    output logic       e1_wpending,
    output word_t      e1_wdata,
    output logic       e1_alt_wen,
    output reg_idx_t   e1_alt_wdst,
    output word_t      e1_alt_wdata
);

    word_t step;                               // 1, 2 or 4 bytes
    word_t disp4;                              // Scaled 4-bit displacement
    word_t disp8;                              // Scaled 8-bit displacement
    word_t rn_dec;                             // Rn minus size
    word_t disp_base;
    word_t reg_base;                           // Rm for loads, Rn for stores

    assign step      = size_bytes(size);
    assign disp4     = word_t'(imm[3:0]) << size;
    assign disp8     = word_t'(imm) << size;
    assign rn_dec    = oph - step;
    assign reg_base  = is_load ? opl : oph;
    // MOV.L store has Rn in [11:8], other disp forms in [7:4]
    assign disp_base = (size == SZ_LONG && !is_load) ? oph : opl;

    always_comb
    begin
        case (mode)
            AM_PREDEC:   addr = rn_dec;
            AM_POSTINC:  addr = opl;
            AM_DISP_RN:  addr = disp_base + disp4;
            AM_R0_RN:    addr = reg_base + r0;
            AM_DISP_GBR: addr = gbr + disp8;
            AM_R0_GBR:   addr = gbr + r0;
            default:     addr = reg_base;      // Plain @Rn / @Rm
        endcase
    end

    // Load result arrives in E2, decremented Rn is ready now
    assign e1_wen       = (is_load && !is_rmw) || (mode == AM_PREDEC);
    assign e1_wpending  = is_load && !is_rmw;
    assign e1_wdata     = rn_dec;
    assign e1_alt_wen   = (mode == AM_POSTINC) && (rl != rh);  // Load wins on Rm == Rn
    assign e1_alt_wdst  = rl;
    assign e1_alt_wdata = opl + step;

endmodule

`default_nettype wire

// File: design/lsu_store_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_store_align
    import lsu_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  byte_ofs_t          addr_lo,
    input  acc_size_t          size,
    input  addr_mode_t         mode,
    input  logic               is_store,
    input  logic               is_rmw,
    input  word_t              wdata,      // Rm operand
    input  word_t              r0,
    input  logic [BYTE_W-1:0]  rmw_byte,   // Modified byte of RMW write pass
    output wmask_t             wmask,
    output logic [DATA_W-1:0]  lane_data
);

    localparam int LANES = DATA_W / 8;

    word_t  src;
    wmask_t mask;

    // R0 is the source for byte/word disp stores and all GBR stores
    assign src = is_rmw ? word_t'(rmw_byte) :
                 (mode == AM_DISP_GBR || (mode == AM_DISP_RN && size != SZ_LONG)) ?
                 r0 : wdata;

    always_comb
    begin
        case (size)
            SZ_BYTE:
            begin
                lane_data = {LANES{src[7:0]}};
                mask      = wmask_t'(1) << addr_lo;
            end
            SZ_WORD:
            begin
                lane_data = {(LANES / 2){src[15:0]}};
                mask      = wmask_t'(3) << {addr_lo[1], 1'b0};  // Halfword aligned
            end
            default:
            begin
                lane_data = {(LANES / 4){src}};
                mask      = '1;
            end
        endcase
    end

    assign wmask = is_store ? mask : '0;       // No lanes on loads

endmodule

`default_nettype wire

// File: design/lsu_e2_stage.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_e2_stage
    import lsu_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic               is_store,
    input  logic               is_rmw,
    input  acc_size_t          size,
    input  byte_ofs_t          addr_lo,
    input  reg_idx_t           wdst,
    input  rmw_state_t         rmw_state,
    input  logic               dm_resp_valid,
    input  logic [DATA_W-1:0]  dm_resp_rdata,
    lsu_e2_if.e1               e2,
    output logic               e2_wen,
    output reg_idx_t           e2_wdst,
    output word_t              e2_wdata,
    output logic               e2_nack,
    output logic [BYTE_W-1:0]  rd_byte
);

    localparam int LANES = DATA_W / 8;

    logic [7:0]  lane [LANES];                 // Response split in bytes
    logic [15:0] ld_half;

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        assign lane[i] = dm_resp_rdata[8*i +: 8];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            e2.valid <= 1'b0;
        else
            e2.valid <= req_valid;             // Already cleared by flush
    end

    always_ff @(posedge clk)
    begin
        e2.is_store <= is_store;
        e2.is_rmw   <= is_rmw;
        e2.size     <= size;
        e2.byte_ofs <= addr_lo;
        e2.wdst     <= wdst;
    end

    assign rd_byte = lane[e2.byte_ofs];
    assign ld_half = {lane[{e2.byte_ofs[1], 1'b1}], lane[{e2.byte_ofs[1], 1'b0}]};

    always_comb
    begin
        case (e2.size)
            SZ_BYTE: e2_wdata = {{24{rd_byte[7]}}, rd_byte};   // Sign extend
            SZ_WORD: e2_wdata = {{16{ld_half[15]}}, ld_half};
            default: e2_wdata = dm_resp_rdata[31:0];
        endcase
    end

    assign e2_wdst = e2.wdst;
    // Replay on no response, and always after the RMW read pass
    assign e2_nack = e2.valid &&
                     (!dm_resp_valid || (e2.is_rmw && rmw_state == RMW_READ));
    assign e2_wen  = e2.valid && dm_resp_valid && !e2.is_store && !e2.is_rmw;

endmodule

`default_nettype wire

// File: design/lsu_rmw_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_rmw_ctrl
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    lsu_e2_if.e2               e2,
    input  logic               dm_resp_valid,
    input  logic [BYTE_W-1:0]  rd_byte,    // Lane picked in E2
    input  rmw_op_t            rmw_op,     // Op of the instruction in E1
    input  logic [BYTE_W-1:0]  imm_byte,
    output rmw_state_t         rmw_state,
    output logic [BYTE_W-1:0]  rmw_wbyte
);

    logic [BYTE_W-1:0] old_byte;               // Memory byte from the read pass
    logic              pass_done;              // RMW pass got its response

    assign pass_done = e2.valid && e2.is_rmw && dm_resp_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
            rmw_state <= RMW_READ;
        else if (pass_done)
            rmw_state <= (rmw_state == RMW_READ) ? RMW_WRITE : RMW_READ;
    end

    always_ff @(posedge clk)
    begin
        if (pass_done && rmw_state == RMW_READ)
            old_byte <= rd_byte;
    end

    always_comb
    begin
        case (rmw_op)
            RMW_AND: rmw_wbyte = old_byte & imm_byte;
            RMW_OR:  rmw_wbyte = old_byte | imm_byte;
            RMW_XOR: rmw_wbyte = old_byte ^ imm_byte;
            default: rmw_wbyte = old_byte;     // Not an RMW, value unused
        endcase
    end

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               e1_flush,
    input  logic               in_valid,
    input  raw_t               in_raw,
    input  word_t              in_r0,
    input  word_t              in_gbr,
    input  word_t              in_opl,
    input  word_t              in_oph,
    output logic               e1_wen,
    output logic               e1_wpending,
    output reg_idx_t           e1_wdst,
    output word_t              e1_wdata,
    output logic               e1_alt_wen,
    output reg_idx_t           e1_alt_wdst,
    output word_t              e1_alt_wdata,
    output logic               e2_wen,
    output reg_idx_t           e2_wdst,
    output word_t              e2_wdata,
    output logic               e2_nack,
    output word_t              dm_req_addr,
    output logic [DATA_W-1:0]  dm_req_wdata,
    output wmask_t             dm_req_wmask,
    output logic               dm_req_wen,
    output logic               dm_req_valid,
    input  logic [DATA_W-1:0]  dm_resp_rdata,
    input  logic               dm_resp_valid
);

    logic              is_load;
    logic              is_store;
    logic              is_rmw;
    acc_size_t         size;
    addr_mode_t        mode;
    rmw_op_t           rmw_op;
    rmw_state_t        rmw_state;
    logic [BYTE_W-1:0] rmw_wbyte;
    logic [BYTE_W-1:0] rd_byte;

    lsu_e2_if e2_bus ();                       // E1 to E2 record

    assign dm_req_wen   = is_store;
    assign dm_req_valid = in_valid && (is_load || is_store) && !e1_flush;

    lsu_decode u_decode (
        .raw(in_raw), .rmw_state(rmw_state), .is_load(is_load), .is_store(is_store),
        .is_rmw(is_rmw), .size(size), .mode(mode), .wdst(e1_wdst), .rmw_op(rmw_op)
    );

    lsu_agen u_agen (
        .opl(in_opl), .oph(in_oph), .r0(in_r0), .gbr(in_gbr), .imm(in_raw[7:0]),
        .mode(mode), .size(size), .is_load(is_load), .is_rmw(is_rmw),
        .rl(in_raw[7:4]), .rh(in_raw[11:8]), .addr(dm_req_addr),
        .e1_wen(e1_wen), .e1_wpending(e1_wpending), .e1_wdata(e1_wdata),
        .e1_alt_wen(e1_alt_wen), .e1_alt_wdst(e1_alt_wdst), .e1_alt_wdata(e1_alt_wdata)
    );

    lsu_store_align #(.DATA_W(DATA_W)) u_align (
        .addr_lo(dm_req_addr[1:0]), .size(size), .mode(mode), .is_store(is_store),
        .is_rmw(is_rmw), .wdata(in_opl), .r0(in_r0), .rmw_byte(rmw_wbyte),
        .wmask(dm_req_wmask), .lane_data(dm_req_wdata)
    );

    lsu_rmw_ctrl u_rmw (
        .clk(clk), .rst(rst), .e2(e2_bus.e2), .dm_resp_valid(dm_resp_valid),
        .rd_byte(rd_byte), .rmw_op(rmw_op), .imm_byte(in_raw[7:0]),
        .rmw_state(rmw_state), .rmw_wbyte(rmw_wbyte)
    );

    lsu_e2_stage #(.DATA_W(DATA_W)) u_e2 (
        .clk(clk), .rst(rst), .req_valid(dm_req_valid), .is_store(is_store),
        .is_rmw(is_rmw), .size(size), .addr_lo(dm_req_addr[1:0]), .wdst(e1_wdst),
        .rmw_state(rmw_state), .dm_resp_valid(dm_resp_valid),
        .dm_resp_rdata(dm_resp_rdata), .e2(e2_bus.e1), .e2_wen(e2_wen),
        .e2_wdst(e2_wdst), .e2_wdata(e2_wdata), .e2_nack(e2_nack), .rd_byte(rd_byte)
    );

endmodule

`default_nettype wire

// File: bench/lsu_assert.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_assert
    import lsu_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   e1_flush,
    input logic   e2_nack,
    input logic   e2_wen,
    input logic   dm_req_valid,
    input logic   dm_req_wen,
    input wmask_t dm_req_wmask
);

    // E2 is empty in the cycle after reset
    a_reset_quiet: assert property (@(posedge clk) rst |=> !e2_nack && !e2_wen)
        else $error("E2 nack or write right after reset");

    a_load_mask: assert property (@(posedge clk) disable iff (rst)
        dm_req_valid && !dm_req_wen |-> dm_req_wmask == '0)
        else $error("Byte lanes enabled on a load request");

    // Flushed E1 leaves E2 idle
    a_flush: assert property (@(posedge clk) disable iff (rst)
        e1_flush |=> !e2_nack && !e2_wen)
        else $error("E2 nack or write after a flushed E1");

    // Any E2 effect needs a request one cycle earlier
    a_e2_cause: assert property (@(posedge clk) disable iff (rst)
        e2_nack || e2_wen |-> $past(dm_req_valid))
        else $error("E2 activity without a request");

    a_wen_nack: assert property (@(posedge clk) disable iff (rst) e2_wen |-> !e2_nack)
        else $error("Load write and nack in the same cycle");

endmodule

bind lsu_top lsu_assert u_assert (
    .clk(clk), .rst(rst), .e1_flush(e1_flush), .e2_nack(e2_nack), .e2_wen(e2_wen),
    .dm_req_valid(dm_req_valid), .dm_req_wen(dm_req_wen), .dm_req_wmask(dm_req_wmask)
);

`default_nettype wire

// File: bench/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int NUM_INSTR = 400;            // Random instructions per run
    localparam int MAX_TRIES = 40;             // Replay limit per instruction

    logic       clk = 1'b0;
    logic       rst;
    logic       e1_flush;
    logic       in_valid;
    raw_t       in_raw;
    word_t      in_r0;
    word_t      in_gbr;
    word_t      in_opl;
    word_t      in_oph;
    logic       e1_wen;
    logic       e1_wpending;
    reg_idx_t   e1_wdst;
    word_t      e1_wdata;
    logic       e1_alt_wen;
    reg_idx_t   e1_alt_wdst;
    word_t      e1_alt_wdata;
    logic       e2_wen;
    reg_idx_t   e2_wdst;
    word_t      e2_wdata;
    logic       e2_nack;
    word_t      dm_req_addr;
    word_t      dm_req_wdata;
    wmask_t     dm_req_wmask;
    logic       dm_req_wen;
    logic       dm_req_valid;
    word_t      dm_resp_rdata;
    logic       dm_resp_valid;

    word_t      mem [256];                     // Memory seen by the DUT
    word_t      ref_mem [256];                 // Model copy
    word_t      regs [16];                     // Register file for operands
    word_t      gbr_val;

    // Current instruction as the model sees it
    raw_t       raw_v;
    int         kind;
    reg_idx_t   rn;
    reg_idx_t   rm;
    logic [1:0] sz;
    logic [7:0] imm8;
    logic [1:0] op_e;                          // raw[9:8] of the RMW forms
    word_t      addr_e;
    word_t      src_e;                         // Store value before replication
    reg_idx_t   wdst_e;
    logic       ld_e;                          // Plain load without RMW
    logic       st_e;                          // Plain store without RMW
    logic       rmw_e;
    logic       predec_e;
    logic       postinc_e;
    logic       rmw_pass;                      // 0 read pass, 1 write pass
    logic [7:0] old_byte_e;

    lsu_top i_dut (.*);

    always #20 clk = ~clk;                     // 40 ns period

    task automatic check(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic word_t step_of(input logic [1:0] s);
        case (s)
            2'd0:    return 32'd1;
            2'd1:    return 32'd2;
            default: return 32'd4;
        endcase
    endfunction

    function automatic word_t replicate(input logic [1:0] s, input word_t v);
        case (s)
            2'd0:    return {v[7:0], v[7:0], v[7:0], v[7:0]};
            2'd1:    return {v[15:0], v[15:0]};
            default: return v;
        endcase
    endfunction

    function automatic wmask_t lane_mask(input logic [1:0] s, input logic [1:0] ofs);
        case (s)
            2'd0:    return wmask_t'(4'b0001 << ofs);
            2'd1:    return ofs[1] ? 4'b1100 : 4'b0011;  // Halfword lanes
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t load_value(input logic [1:0] s, input logic [1:0] ofs,
                                         input word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*ofs +: 8];
        h = ofs[1] ? w[31:16] : w[15:0];
        case (s)
            2'd0:    return {{24{b[7]}}, b};   // Signed byte
            2'd1:    return {{16{h[15]}}, h};  // Signed word
            default: return w;
        endcase
    endfunction

    function automatic word_t merge(input word_t old, input word_t data, input wmask_t m);
        word_t r;
        r = old;
        for (int i = 0; i < 4; i++)
        begin
            if (m[i])
                r[8*i +: 8] = data[8*i +: 8];
        end
        return r;
    endfunction

    function automatic logic [7:0] rmw_result(input logic [1:0] op, input logic [7:0] old,
                                              input logic [7:0] imm);
        case (op)
            2'b01:   return old & imm;         // AND.B
            2'b10:   return old ^ imm;         // XOR.B
            default: return old | imm;         // OR.B
        endcase
    endfunction

    // Picks one kept opcode with random fields and operands
    task automatic build_instr();
        kind = int'($urandom_range(12, 0));
        rn   = 4'($urandom);
        rm   = 4'($urandom);
        sz   = 2'($urandom_range(2, 0));
        imm8 = 8'($urandom);
        op_e = 2'($urandom_range(3, 1));
        for (int i = 0; i < 16; i++)
            regs[i] = $urandom;
        gbr_val = $urandom;
        if (kind == 7 && $urandom_range(3, 0) == 0)
            rm = rn;                           // Post-increment onto its own target
        if (kind == 2 || kind == 8)
            sz = 2'($urandom_range(1, 0));
        if (kind == 3 || kind == 9)
            sz = 2'd2;
        ld_e      = (kind >= 6 && kind <= 11);
        st_e      = (kind <= 5);
        rmw_e     = (kind == 12);
        predec_e  = (kind == 1);
        postinc_e = (kind == 7);
        wdst_e    = rn;
        src_e     = regs[rm];
        rmw_pass  = 1'b0;
        case (kind)
            0:  raw_v = {4'h2, rn, rm, 2'b00, sz};
            1:  raw_v = {4'h2, rn, rm, 2'b01, sz};
            2:  raw_v = {7'b1000000, sz[0], rm, imm8[3:0]};
            3:  raw_v = {4'h1, rn, rm, imm8[3:0]};
            4:  raw_v = {4'h0, rn, rm, 2'b01, sz};
            5:  raw_v = {6'b110000, sz, imm8};
            6:  raw_v = {4'h6, rn, rm, 2'b00, sz};
            7:  raw_v = {4'h6, rn, rm, 2'b01, sz};
            8:  raw_v = {7'b1000010, sz[0], rm, imm8[3:0]};
            9:  raw_v = {4'h5, rn, rm, imm8[3:0]};
            10: raw_v = {4'h0, rn, rm, 2'b11, sz};
            11: raw_v = {6'b110001, sz, imm8};
            default:
            begin
                raw_v = {6'b110011, op_e, imm8};
                sz    = 2'd0;                  // RMW is byte only
            end
        endcase
        case (kind)
            0:       addr_e = regs[rn];
            1:       addr_e = regs[rn] - step_of(sz);
            2, 8:    addr_e = regs[rm] + word_t'(imm8[3:0]) * step_of(sz);
            3:       addr_e = regs[rn] + word_t'(imm8[3:0]) * 32'd4;
            4:       addr_e = regs[rn] + regs[0];
            6, 7:    addr_e = regs[rm];
            9:       addr_e = regs[rm] + word_t'(imm8[3:0]) * 32'd4;
            10:      addr_e = regs[rm] + regs[0];
            5, 11:   addr_e = gbr_val + word_t'(imm8) * step_of(sz);
            default: addr_e = gbr_val + regs[0];
        endcase
        if (kind == 2 || kind == 5)
            src_e = regs[0];                   // R0 is the store source
        if (kind == 8 || kind == 11)
            wdst_e = 4'd0;                     // Loads into R0
    endtask

    // Issues once and runs the E2 cycle that follows
    task automatic run_attempt(output logic done);
        logic       flush;
        logic       resp;
        logic       eff_st;
        logic [7:0] new_byte;
        word_t      st_data;
        wmask_t     mask_e;
        logic [7:0] idx;
        logic [7:0] req_idx;
        word_t      req_wdata;
        wmask_t     req_wmask;
        word_t      w;
        flush    = ($urandom_range(9, 0) == 0);
        resp     = ($urandom_range(99, 0) < 80);
        eff_st   = st_e || (rmw_e && rmw_pass);
        new_byte = rmw_result(op_e, old_byte_e, imm8);
        st_data  = replicate(sz, rmw_e ? word_t'(new_byte) : src_e);
        mask_e   = eff_st ? lane_mask(sz, addr_e[1:0]) : 4'b0000;
        idx      = addr_e[9:2];
        done     = 1'b0;

        @(posedge clk);
        #2;
        in_valid      = 1'b1;
        in_raw        = raw_v;
        in_r0         = regs[0];
        in_gbr        = gbr_val;
        in_opl        = regs[raw_v[7:4]];
        in_oph        = regs[raw_v[11:8]];
        e1_flush      = flush;
        dm_resp_valid = 1'b0;
        @(negedge clk);
        check("e1_wen", word_t'(ld_e || predec_e), word_t'(e1_wen));
        check("e1_wpending", word_t'(ld_e), word_t'(e1_wpending));
        if (ld_e || predec_e)
            check("e1_wdst", word_t'(wdst_e), word_t'(e1_wdst));
        if (predec_e)
            check("e1_wdata", regs[rn] - step_of(sz), e1_wdata);
        check("e1_alt_wen", word_t'(postinc_e && rm != rn), word_t'(e1_alt_wen));
        if (postinc_e && rm != rn)
        begin
            check("e1_alt_wdst", word_t'(rm), word_t'(e1_alt_wdst));
            check("e1_alt_wdata", regs[rm] + step_of(sz), e1_alt_wdata);
        end
        check("dm_req_valid", word_t'(!flush), word_t'(dm_req_valid));
        if (!flush)
        begin
            check("dm_req_addr", addr_e, dm_req_addr);
            check("dm_req_wen", word_t'(eff_st), word_t'(dm_req_wen));
            check("dm_req_wmask", word_t'(mask_e), word_t'(dm_req_wmask));
            if (eff_st)
                check("dm_req_wdata", st_data, dm_req_wdata);
        end
        req_idx   = dm_req_addr[9:2];          // Memory side keeps the request
        req_wdata = dm_req_wdata;
        req_wmask = dm_req_wmask;

        @(posedge clk);
        #2;
        in_valid      = 1'b0;
        e1_flush      = 1'b0;
        dm_resp_valid = resp && !flush;        // Memory answers only a request
        dm_resp_rdata = dm_resp_valid ? mem[req_idx] : $urandom;
        @(negedge clk);
        if (flush || !resp)
        begin
            check("e2_nack", word_t'(!flush), word_t'(e2_nack));  // Replay unless flushed
            check("e2_wen", 32'd0, word_t'(e2_wen));
        end
        else if (rmw_e && !rmw_pass)
        begin
            check("e2_nack", 32'd1, word_t'(e2_nack));
            check("e2_wen", 32'd0, word_t'(e2_wen));
            w          = ref_mem[idx];
            old_byte_e = w[8*addr_e[1:0] +: 8];
            rmw_pass   = 1'b1;
        end
        else if (eff_st)
        begin
            check("e2_nack", 32'd0, word_t'(e2_nack));
            check("e2_wen", 32'd0, word_t'(e2_wen));
            mem[req_idx] = merge(mem[req_idx], req_wdata, req_wmask);
            ref_mem[idx] = merge(ref_mem[idx], st_data, mask_e);
            check("mem_after_write", ref_mem[idx], mem[idx]);
            rmw_pass = 1'b0;
            done     = 1'b1;
        end
        else
        begin
            check("e2_nack", 32'd0, word_t'(e2_nack));
            check("e2_wen", 32'd1, word_t'(e2_wen));
            check("e2_wdst", word_t'(wdst_e), word_t'(e2_wdst));
            check("e2_wdata", load_value(sz, addr_e[1:0], ref_mem[idx]), e2_wdata);
            done = 1'b1;
        end
    endtask

    // Replays after nack or flush until the instruction retires
    task automatic run_instr();
        int   tries;
        logic done;
        build_instr();
        tries = 0;
        done  = 1'b0;
        while (!done)
        begin
            if (tries >= MAX_TRIES)
            begin
                $display("Instruction %h did not retire within %0d attempts", raw_v, tries);
                $display("Simulation failed");
                $fatal(1, "Replay limit reached");
            end
            else
            begin
                run_attempt(done);
                tries++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h00ff9e6f));
        rst           = 1'b1;
        e1_flush      = 1'b0;
        in_valid      = 1'b0;
        in_raw        = '0;
        in_r0         = '0;
        in_gbr        = '0;
        in_opl        = '0;
        in_oph        = '0;
        dm_resp_valid = 1'b0;
        dm_resp_rdata = '0;
        old_byte_e    = '0;
        rmw_pass      = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            mem[i]     = word_t'((i + 1) * 32'h9e3779b9);  // Distinct per word
            ref_mem[i] = mem[i];
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++)
            run_instr();
        @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/lsu_pkg.sv
design/lsu_e2_if.sv
design/lsu_decode.sv
design/lsu_agen.sv
design/lsu_store_align.sv
design/lsu_e2_stage.sv
design/lsu_rmw_ctrl.sv
design/lsu_top.sv
bench/lsu_assert.sv
bench/lsu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
